// ==== hazard_consts.svh ====
`ifndef HAZARD_CONSTS_SVH
`define HAZARD_CONSTS_SVH

// Primary opcodes, instr[31:26]
`define OP_SPECIAL  6'b000000
`define OP_J        6'b000010
`define OP_JAL      6'b000011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_BLEZ     6'b000110
`define OP_BGTZ     6'b000111
`define OP_ADDIU    6'b001001
`define OP_ORI      6'b001101
`define OP_LUI      6'b001111
`define OP_LW       6'b100011
`define OP_SW       6'b101011

// Funct codes under OP_SPECIAL, instr[5:0]
`define FN_JR       6'b001000
`define FN_JALR     6'b001001
`define FN_ADDU     6'b100001
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_SLT      6'b101010

// Register numbers with a fixed meaning
`define REG_LINK    5'd31  // Written by jal
`define REG_ZERO    5'd0   // Hardwired zero

`endif

// ==== hazardPkg.sv ====
package hazardPkg;

	typedef logic [4:0] regNumT;

	// Raw MIPS instruction word
	typedef struct packed {
		logic [5:0] opcode;
		regNumT rs;
		regNumT rt;
		regNumT rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instrT;

	// Kind of value an instruction writes back
	typedef enum logic [1:0] {
		prodNone = 2'd0,
		prodAlu  = 2'd1,
		prodMem  = 2'd2,
		prodPc   = 2'd3  // Return address of jal/jalr
	} producerT;

	typedef struct packed {
		logic isRAlu;
		logic isIAlu;
		logic isLoad;
		logic isStore;
		logic isBranchTwo;  // beq, bne
		logic isBranchOne;  // blez, bgtz
		logic isJump;       // j, jal
		logic isJumpReg;    // jr, jalr
		regNumT dest;
		producerT prod;
	} instrInfoT;

	// Bypass mux select for one operand
	typedef enum logic [3:0] {
		selNormal = 4'd0,
		fromEAlu  = 4'd1,
		fromMAlu  = 4'd2,
		fromWAlu  = 4'd3,
		fromWMem  = 4'd4,
		fromEPc   = 4'd5,
		fromMPc   = 4'd6,
		fromWPc   = 4'd7
	} fwdSelT;

	typedef enum logic [2:0] {
		roleCmpA    = 3'd0,
		roleCmpB    = 3'd1,
		roleJumpReg = 3'd2,
		roleAluA    = 3'd3,
		roleAluB    = 3'd4,
		roleStoreE  = 3'd5,
		roleStoreM  = 3'd6
	} operandRoleT;

	// Pipeline register controls
	typedef struct packed {
		logic pcWr;
		logic weD;
		logic weE;
		logic weM;
		logic clearD;
		logic clearE;
		logic clearM;
	} stageCtrlT;

endpackage

// ==== instrDecoder.sv ====
`timescale 1ns/100ps
`include "hazard_consts.svh"

module instrDecoder (
	input hazardPkg::instrT instr,
	output hazardPkg::instrInfoT info
);

	always_comb
	begin
		info = '0;  // Anything not listed below is a nop
		info.dest = `REG_ZERO;
		info.prod = hazardPkg::prodNone;
		case (instr.opcode)
			`OP_SPECIAL:
			begin
				case (instr.funct)
					`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_SLT:
					begin
						info.isRAlu = 1'b1;
						info.dest = instr.rd;
						info.prod = hazardPkg::prodAlu;
					end
					`FN_JR:
					begin
						info.isJumpReg = 1'b1;
					end
					`FN_JALR:
					begin
						info.isJumpReg = 1'b1;
						info.dest = instr.rd;  // Link goes to rd, not r31
						info.prod = hazardPkg::prodPc;
					end
					default: ;
				endcase
			end
			`OP_ADDIU, `OP_ORI, `OP_LUI:
			begin
				info.isIAlu = 1'b1;
				info.dest = instr.rt;
				info.prod = hazardPkg::prodAlu;
			end
			`OP_LW:
			begin
				info.isLoad = 1'b1;
				info.dest = instr.rt;
				info.prod = hazardPkg::prodMem;
			end
			`OP_SW:
			begin
				info.isStore = 1'b1;
			end
			`OP_BEQ, `OP_BNE:
			begin
				info.isBranchTwo = 1'b1;
			end
			`OP_BLEZ, `OP_BGTZ:
			begin
				info.isBranchOne = 1'b1;
			end
			`OP_J:
			begin
				info.isJump = 1'b1;
			end
			`OP_JAL:
			begin
				info.isJump = 1'b1;
				info.dest = `REG_LINK;
				info.prod = hazardPkg::prodPc;
			end
			default: ;
		endcase
	end

endmodule

// ==== forwardSelect.sv ====
`timescale 1ns/100ps
`include "hazard_consts.svh"

module forwardSelect #(
	parameter hazardPkg::operandRoleT Role = hazardPkg::roleAluA
) (
	input hazardPkg::instrT instr,
	input hazardPkg::instrInfoT info,
	input hazardPkg::instrInfoT infoE,
	input hazardPkg::instrInfoT infoM,
	input hazardPkg::instrInfoT infoW,
	output hazardPkg::fwdSelT sel
);

	localparam bit ReadsRs = (Role == hazardPkg::roleCmpA)
		|| (Role == hazardPkg::roleJumpReg)
		|| (Role == hazardPkg::roleAluA);
	// Consumers in D see E, M and W
	localparam bit RangeE = (Role == hazardPkg::roleCmpA)
		|| (Role == hazardPkg::roleCmpB)
		|| (Role == hazardPkg::roleJumpReg);
	localparam bit RangeM = RangeE
		|| (Role == hazardPkg::roleAluA)
		|| (Role == hazardPkg::roleAluB);

	logic needed;
	hazardPkg::regNumT src;

	function automatic logic writes(
		input hazardPkg::instrInfoT p,
		input hazardPkg::regNumT r
	);
		return (p.dest == r) && (p.prod != hazardPkg::prodNone);
	endfunction

	function automatic hazardPkg::fwdSelT pickSel(
		input hazardPkg::producerT prod,
		input hazardPkg::fwdSelT aluSel,
		input hazardPkg::fwdSelT memSel,
		input hazardPkg::fwdSelT pcSel
	);
		case (prod)
			hazardPkg::prodAlu: pickSel = aluSel;
			hazardPkg::prodMem: pickSel = memSel;
			hazardPkg::prodPc: pickSel = pcSel;
			default: pickSel = hazardPkg::selNormal;
		endcase
	endfunction

	assign src = ReadsRs ? instr.rs : instr.rt;

	always_comb
	begin
		case (Role)
			hazardPkg::roleCmpA: needed = info.isBranchOne | info.isBranchTwo;
			hazardPkg::roleCmpB: needed = info.isBranchTwo;
			hazardPkg::roleJumpReg: needed = info.isJumpReg;
			hazardPkg::roleAluA: needed = info.isRAlu | info.isIAlu | info.isLoad | info.isStore;
			hazardPkg::roleAluB: needed = info.isRAlu;
			default: needed = info.isStore;  // Store data in E or M
		endcase
	end

	// Nearest stage wins; a load still in E or M is handled by the stall
	always_comb
	begin
		sel = hazardPkg::selNormal;
		if (needed && (src != `REG_ZERO))
		begin
			if (RangeE && writes(infoE, src))
				sel = pickSel(infoE.prod, hazardPkg::fromEAlu, hazardPkg::selNormal,
					hazardPkg::fromEPc);
			else if (RangeM && writes(infoM, src))
				sel = pickSel(infoM.prod, hazardPkg::fromMAlu, hazardPkg::selNormal,
					hazardPkg::fromMPc);
			else if (writes(infoW, src))
				sel = pickSel(infoW.prod, hazardPkg::fromWAlu, hazardPkg::fromWMem,
					hazardPkg::fromWPc);
		end
	end

endmodule

// ==== stallControl.sv ====
`timescale 1ns/100ps
`include "hazard_consts.svh"

module stallControl (
	input hazardPkg::instrT instrD,
	input hazardPkg::instrT instrE,
	input hazardPkg::instrT instrM,
	input hazardPkg::instrInfoT infoD,
	input hazardPkg::instrInfoT infoE,
	input hazardPkg::instrInfoT infoM,
	input logic branchTaken,
	output hazardPkg::stageCtrlT ctrl
);

	hazardPkg::regNumT loadRegM;
	logic eNeedsRs;
	logic eNeedsRt;
	logic dNeedsRs;
	logic dNeedsRt;
	logic eBusy;
	logic rsPendingD;
	logic rtPendingD;
	logic loadUseE;
	logic useD;
	logic redirect;

	assign loadRegM = infoM.isLoad ? instrM.rt : `REG_ZERO;  // lw target, else r0

	assign eNeedsRs = infoE.isRAlu | infoE.isIAlu | infoE.isLoad | infoE.isStore;
	assign eNeedsRt = infoE.isRAlu;
	assign loadUseE = (loadRegM != `REG_ZERO)
		&& ((eNeedsRs && (instrE.rs == loadRegM)) || (eNeedsRt && (instrE.rt == loadRegM)));

	// E result not ready for the comparator or jump target in D
	assign eBusy = (infoE.prod == hazardPkg::prodAlu) || (infoE.prod == hazardPkg::prodMem);
	assign dNeedsRs = infoD.isBranchOne | infoD.isBranchTwo | infoD.isJumpReg;
	assign dNeedsRt = infoD.isBranchTwo;
	assign rsPendingD = (instrD.rs != `REG_ZERO)
		&& ((eBusy && (instrD.rs == infoE.dest)) || (instrD.rs == loadRegM));
	assign rtPendingD = (instrD.rt != `REG_ZERO)
		&& ((eBusy && (instrD.rt == infoE.dest)) || (instrD.rt == loadRegM));
	assign useD = (dNeedsRs && rsPendingD) || (dNeedsRt && rtPendingD);

	assign redirect = infoD.isJump || infoD.isJumpReg
		|| ((infoD.isBranchOne || infoD.isBranchTwo) && branchTaken);

	always_comb
	begin
		ctrl = '0;
		if (loadUseE)
		begin
			ctrl.clearM = 1'b1;  // Bubble into M, hold PC, D and E
		end
		else if (useD)
		begin
			ctrl.weM = 1'b1;
			ctrl.clearE = 1'b1;  // Bubble into E, hold PC and D
		end
		else if (redirect)
		begin
			ctrl.pcWr = 1'b1;
			ctrl.weE = 1'b1;
			ctrl.weM = 1'b1;
			ctrl.clearD = 1'b1;  // Drop the fetched instruction
		end
		else
		begin
			ctrl.pcWr = 1'b1;
			ctrl.weD = 1'b1;
			ctrl.weE = 1'b1;
			ctrl.weM = 1'b1;
		end
	end

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit (
	input hazardPkg::instrT instrD,
	input hazardPkg::instrT instrE,
	input hazardPkg::instrT instrM,
	input hazardPkg::instrT instrW,
	input logic branchTaken,
	output hazardPkg::fwdSelT selCmpA,
	output hazardPkg::fwdSelT selCmpB,
	output hazardPkg::fwdSelT selJumpReg,
	output hazardPkg::fwdSelT selAluA,
	output hazardPkg::fwdSelT selAluB,
	output hazardPkg::fwdSelT selStoreE,
	output hazardPkg::fwdSelT selStoreM,
	output hazardPkg::stageCtrlT ctrl
);

	hazardPkg::instrInfoT infoD;
	hazardPkg::instrInfoT infoE;
	hazardPkg::instrInfoT infoM;
	hazardPkg::instrInfoT infoW;

	instrDecoder u_decoderD (.instr(instrD), .info(infoD));
	instrDecoder u_decoderE (.instr(instrE), .info(infoE));
	instrDecoder u_decoderM (.instr(instrM), .info(infoM));
	instrDecoder u_decoderW (.instr(instrW), .info(infoW));

	// Operands consumed in D
	forwardSelect #(.Role(hazardPkg::roleCmpA)) u_fwdCmpA (
		.instr(instrD), .info(infoD),
		.infoE(infoE), .infoM(infoM), .infoW(infoW),
		.sel(selCmpA)
	);
	forwardSelect #(.Role(hazardPkg::roleCmpB)) u_fwdCmpB (
		.instr(instrD), .info(infoD),
		.infoE(infoE), .infoM(infoM), .infoW(infoW),
		.sel(selCmpB)
	);
	forwardSelect #(.Role(hazardPkg::roleJumpReg)) u_fwdJumpReg (
		.instr(instrD), .info(infoD),
		.infoE(infoE), .infoM(infoM), .infoW(infoW),
		.sel(selJumpReg)
	);

	// Operands consumed in E
	forwardSelect #(.Role(hazardPkg::roleAluA)) u_fwdAluA (
		.instr(instrE), .info(infoE),
		.infoE(infoE), .infoM(infoM), .infoW(infoW),
		.sel(selAluA)
	);
	forwardSelect #(.Role(hazardPkg::roleAluB)) u_fwdAluB (
		.instr(instrE), .info(infoE),
		.infoE(infoE), .infoM(infoM), .infoW(infoW),
		.sel(selAluB)
	);
	forwardSelect #(.Role(hazardPkg::roleStoreE)) u_fwdStoreE (
		.instr(instrE), .info(infoE),
		.infoE(infoE), .infoM(infoM), .infoW(infoW),
		.sel(selStoreE)
	);

	forwardSelect #(.Role(hazardPkg::roleStoreM)) u_fwdStoreM (
		.instr(instrM), .info(infoM),
		.infoE(infoE), .infoM(infoM), .infoW(infoW),
		.sel(selStoreM)  // sw data at the memory port
	);

	stallControl u_stallControl (
		.instrD(instrD),
		.instrE(instrE),
		.instrM(instrM),
		.infoD(infoD),
		.infoE(infoE),
		.infoM(infoM),
		.branchTaken(branchTaken),
		.ctrl(ctrl)
	);

endmodule

// ==== hazardUnitTb.sv ====
`timescale 1ns/100ps
`include "hazard_consts.svh"

module hazardUnitTb;

	typedef struct packed {
		hazardPkg::instrT instrD;
		hazardPkg::instrT instrE;
		hazardPkg::instrT instrM;
		hazardPkg::instrT instrW;
		logic taken;
		hazardPkg::fwdSelT expCmpA;
		hazardPkg::fwdSelT expCmpB;
		hazardPkg::fwdSelT expJumpReg;
		hazardPkg::fwdSelT expAluA;
		hazardPkg::fwdSelT expAluB;
		hazardPkg::fwdSelT expStoreE;
		hazardPkg::fwdSelT expStoreM;
		hazardPkg::stageCtrlT expCtrl;
	} vectorT;

	// Short names for the select values in the table
	localparam hazardPkg::fwdSelT fNone = hazardPkg::selNormal;
	localparam hazardPkg::fwdSelT fEAlu = hazardPkg::fromEAlu;
	localparam hazardPkg::fwdSelT fMAlu = hazardPkg::fromMAlu;
	localparam hazardPkg::fwdSelT fWAlu = hazardPkg::fromWAlu;
	localparam hazardPkg::fwdSelT fWMem = hazardPkg::fromWMem;
	localparam hazardPkg::fwdSelT fEPc = hazardPkg::fromEPc;
	localparam hazardPkg::fwdSelT fMPc = hazardPkg::fromMPc;
	localparam hazardPkg::fwdSelT fWPc = hazardPkg::fromWPc;

	// {pcWr, weD, weE, weM, clearD, clearE, clearM}
	localparam hazardPkg::stageCtrlT ctrlNormal = 7'b1111000;
	localparam hazardPkg::stageCtrlT ctrlLoadUse = 7'b0000001;
	localparam hazardPkg::stageCtrlT ctrlUseD = 7'b0001010;
	localparam hazardPkg::stageCtrlT ctrlRedirect = 7'b1011100;

	localparam hazardPkg::instrT nop = '0;

	logic clk = 1'b0;
	logic arstN = 1'b0;
	hazardPkg::instrT instrD;
	hazardPkg::instrT instrE;
	hazardPkg::instrT instrM;
	hazardPkg::instrT instrW;
	logic branchTaken;
	hazardPkg::fwdSelT selCmpA;
	hazardPkg::fwdSelT selCmpB;
	hazardPkg::fwdSelT selJumpReg;
	hazardPkg::fwdSelT selAluA;
	hazardPkg::fwdSelT selAluB;
	hazardPkg::fwdSelT selStoreE;
	hazardPkg::fwdSelT selStoreM;
	hazardPkg::stageCtrlT ctrl;

	vectorT vectors[$];
	int vecIdx;
	int checks = 0;
	int errors = 0;
	int cycleCount = 0;
	int cycleLimit;

	hazardUnit u_hazardUnit (
		.instrD(instrD),
		.instrE(instrE),
		.instrM(instrM),
		.instrW(instrW),
		.branchTaken(branchTaken),
		.selCmpA(selCmpA),
		.selCmpB(selCmpB),
		.selJumpReg(selJumpReg),
		.selAluA(selAluA),
		.selAluB(selAluB),
		.selStoreE(selStoreE),
		.selStoreM(selStoreM),
		.ctrl(ctrl)
	);

	always #10 clk = ~clk;  // 20 ns period

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Checks run: %0d, errors: %0d", checks, errors);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial
	begin
		repeat (16) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
	end

	// Unused shamt bits are random
	function automatic hazardPkg::instrT rType(input logic [5:0] funct,
		input hazardPkg::regNumT rs, input hazardPkg::regNumT rt, input hazardPkg::regNumT rd);
		hazardPkg::instrT ins;
		logic [31:0] r;
		r = $urandom;
		ins.opcode = `OP_SPECIAL;
		ins.rs = rs;
		ins.rt = rt;
		ins.rd = rd;
		ins.shamt = r[4:0];
		ins.funct = funct;
		return ins;
	endfunction

	// Immediate is random
	function automatic hazardPkg::instrT iType(input logic [5:0] op,
		input hazardPkg::regNumT rs, input hazardPkg::regNumT rt);
		hazardPkg::instrT ins;
		ins = hazardPkg::instrT'($urandom);
		ins.opcode = op;
		ins.rs = rs;
		ins.rt = rt;
		return ins;
	endfunction

	function automatic hazardPkg::instrT jType(input logic [5:0] op);
		hazardPkg::instrT ins;
		ins = hazardPkg::instrT'($urandom);  // Random jump target
		ins.opcode = op;
		return ins;
	endfunction

	task automatic addVector(input hazardPkg::instrT d, input hazardPkg::instrT e,
		input hazardPkg::instrT m, input hazardPkg::instrT w, input logic taken,
		input hazardPkg::fwdSelT cmpA, input hazardPkg::fwdSelT cmpB,
		input hazardPkg::fwdSelT jumpReg, input hazardPkg::fwdSelT aluA,
		input hazardPkg::fwdSelT aluB, input hazardPkg::fwdSelT storeE,
		input hazardPkg::fwdSelT storeM, input hazardPkg::stageCtrlT ctrlExp);
		vectorT v;
		v.instrD = d;
		v.instrE = e;
		v.instrM = m;
		v.instrW = w;
		v.taken = taken;
		v.expCmpA = cmpA;
		v.expCmpB = cmpB;
		v.expJumpReg = jumpReg;
		v.expAluA = aluA;
		v.expAluB = aluB;
		v.expStoreE = storeE;
		v.expStoreM = storeM;
		v.expCtrl = ctrlExp;
		vectors.push_back(v);
	endtask

	task automatic checkSel(input string name, input hazardPkg::fwdSelT expVal,
		input hazardPkg::fwdSelT actVal);
		checks++;
		assert (actVal === expVal)
		else
		begin
			errors++;
			$display("Fail %0t vector %0d %s expected %s got %s", $time, vecIdx, name,
				expVal.name(), actVal.name());
		end
	endtask

	task automatic checkCtrl(input hazardPkg::stageCtrlT expVal,
		input hazardPkg::stageCtrlT actVal);
		checks++;
		assert (actVal === expVal)
		else
		begin
			errors++;
			$display("Fail %0t vector %0d ctrl expected %b got %b", $time, vecIdx,
				expVal, actVal);
		end
	endtask

	task automatic buildTable();
		// All nop
		addVector(nop, nop, nop, nop, 1'b0,
			fNone, fNone, fNone, fNone, fNone, fNone, fNone, ctrlNormal);
		// E consumers, M and W producers
		addVector(nop, rType(`FN_ADDU, 5'd1, 5'd2, 5'd3), rType(`FN_ADDU, 5'd4, 5'd5, 5'd1),
			iType(`OP_ADDIU, 5'd6, 5'd2), 1'b0,
			fNone, fNone, fNone, fMAlu, fWAlu, fNone, fNone, ctrlNormal);
		addVector(nop, rType(`FN_SUBU, 5'd1, 5'd2, 5'd3), iType(`OP_ORI, 5'd7, 5'd2),
			rType(`FN_OR, 5'd8, 5'd9, 5'd1), 1'b0,
			fNone, fNone, fNone, fWAlu, fMAlu, fNone, fNone, ctrlNormal);
		addVector(nop, rType(`FN_ADDU, 5'd1, 5'd1, 5'd3), rType(`FN_AND, 5'd4, 5'd5, 5'd1),
			rType(`FN_SLT, 5'd6, 5'd7, 5'd1), 1'b0,
			fNone, fNone, fNone, fMAlu, fMAlu, fNone, fNone, ctrlNormal);
		// Link values for jump register in D
		addVector(rType(`FN_JR, 5'd31, 5'd0, 5'd0), jType(`OP_JAL), nop, nop, 1'b0,
			fNone, fNone, fEPc, fNone, fNone, fNone, fNone, ctrlRedirect);
		addVector(rType(`FN_JR, 5'd5, 5'd0, 5'd0), nop, nop,
			rType(`FN_JALR, 5'd10, 5'd0, 5'd5), 1'b0,
			fNone, fNone, fWPc, fNone, fNone, fNone, fNone, ctrlRedirect);
		addVector(rType(`FN_JALR, 5'd6, 5'd0, 5'd9), nop,
			rType(`FN_JALR, 5'd11, 5'd0, 5'd6), nop, 1'b0,
			fNone, fNone, fMPc, fNone, fNone, fNone, fNone, ctrlRedirect);
		// Load-use in E
		addVector(nop, rType(`FN_ADDU, 5'd4, 5'd5, 5'd3), iType(`OP_LW, 5'd12, 5'd4), nop, 1'b0,
			fNone, fNone, fNone, fNone, fNone, fNone, fNone, ctrlLoadUse);
		addVector(nop, rType(`FN_ADDU, 5'd4, 5'd5, 5'd3), nop, iType(`OP_LW, 5'd12, 5'd4), 1'b0,
			fNone, fNone, fNone, fWMem, fNone, fNone, fNone, ctrlNormal);
		addVector(nop, rType(`FN_ADDU, 5'd6, 5'd7, 5'd3), iType(`OP_LW, 5'd1, 5'd7), nop, 1'b0,
			fNone, fNone, fNone, fNone, fNone, fNone, fNone, ctrlLoadUse);
		// Branches in D
		addVector(iType(`OP_BEQ, 5'd2, 5'd8), rType(`FN_ADDU, 5'd13, 5'd14, 5'd2), nop, nop, 1'b0,
			fEAlu, fNone, fNone, fNone, fNone, fNone, fNone, ctrlUseD);
		addVector(iType(`OP_BNE, 5'd9, 5'd3), nop, iType(`OP_LW, 5'd15, 5'd3), nop, 1'b1,
			fNone, fNone, fNone, fNone, fNone, fNone, fNone, ctrlUseD);
		addVector(iType(`OP_BEQ, 5'd0, 5'd0), rType(`FN_ADDU, 5'd1, 5'd2, 5'd0),
			iType(`OP_LW, 5'd3, 5'd0), nop, 1'b0,
			fNone, fNone, fNone, fNone, fNone, fNone, fNone, ctrlNormal);
		addVector(iType(`OP_BGTZ, 5'd4, 5'd0), nop, nop, nop, 1'b1,
			fNone, fNone, fNone, fNone, fNone, fNone, fNone, ctrlRedirect);
		addVector(iType(`OP_BEQ, 5'd4, 5'd5), nop, nop, rType(`FN_ADDU, 5'd1, 5'd2, 5'd5), 1'b0,
			fNone, fWAlu, fNone, fNone, fNone, fNone, fNone, ctrlNormal);
		addVector(iType(`OP_BLEZ, 5'd6, 5'd0), nop, iType(`OP_ADDIU, 5'd1, 5'd6), nop, 1'b0,
			fMAlu, fNone, fNone, fNone, fNone, fNone, fNone, ctrlNormal);
		// Store data
		addVector(nop, iType(`OP_SW, 5'd1, 5'd5), nop, rType(`FN_ADDU, 5'd2, 5'd3, 5'd5), 1'b0,
			fNone, fNone, fNone, fNone, fNone, fWAlu, fNone, ctrlNormal);
		addVector(nop, nop, iType(`OP_SW, 5'd2, 5'd6), iType(`OP_LW, 5'd3, 5'd6), 1'b0,
			fNone, fNone, fNone, fNone, fNone, fNone, fWMem, ctrlNormal);
		addVector(nop, iType(`OP_SW, 5'd12, 5'd7), iType(`OP_SW, 5'd13, 5'd8),
			rType(`FN_ADDU, 5'd1, 5'd2, 5'd9), 1'b0,
			fNone, fNone, fNone, fNone, fNone, fNone, fNone, ctrlNormal);
		addVector(nop, iType(`OP_SW, 5'd10, 5'd11), rType(`FN_ADDU, 5'd1, 5'd2, 5'd11), nop, 1'b0,
			fNone, fNone, fNone, fNone, fNone, fNone, fNone, ctrlNormal);
		// Plain jump
		addVector(jType(`OP_JAL), nop, nop, nop, 1'b0,
			fNone, fNone, fNone, fNone, fNone, fNone, fNone, ctrlRedirect);
	endtask

	initial
	begin
		instrD = nop;
		instrE = nop;
		instrM = nop;
		instrW = nop;
		branchTaken = 1'b0;
		void'($urandom(32754));
		buildTable();
		cycleLimit = vectors.size() + 16 + 20;
		@(posedge arstN);
		for (vecIdx = 0; vecIdx < vectors.size(); vecIdx++)
		begin
			@(negedge clk);
			instrD = vectors[vecIdx].instrD;
			instrE = vectors[vecIdx].instrE;
			instrM = vectors[vecIdx].instrM;
			instrW = vectors[vecIdx].instrW;
			branchTaken = vectors[vecIdx].taken;
			@(posedge clk);
			checkSel("selCmpA", vectors[vecIdx].expCmpA, selCmpA);
			checkSel("selCmpB", vectors[vecIdx].expCmpB, selCmpB);
			checkSel("selJumpReg", vectors[vecIdx].expJumpReg, selJumpReg);
			checkSel("selAluA", vectors[vecIdx].expAluA, selAluA);
			checkSel("selAluB", vectors[vecIdx].expAluB, selAluB);
			checkSel("selStoreE", vectors[vecIdx].expStoreE, selStoreE);
			checkSel("selStoreM", vectors[vecIdx].expStoreM, selStoreM);
			checkCtrl(vectors[vecIdx].expCtrl, ctrl);
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+.
hazardPkg.sv
instrDecoder.sv
forwardSelect.sv
stallControl.sv
hazardUnit.sv
hazardUnitTb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary -f sources.f --top-module hazardUnitTb
	out=$$(./obj_dir/VhazardUnitTb); echo "$$out"; echo "$$out" | grep -qF "=== PASS ==="

clean:
	rm -rf obj_dir
